//--- include/periph_config.svh
/*
 * Fixed constants of the peripheral glue: I/O port addresses,
 * EMS page frame selectors, page count and reset values
 */

`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// I/O ports
`define PERIPH_EMS_PORT_BASE    16'h0260
`define PERIPH_KBD_PORT         16'h0060

// EMS page registers
`define PERIPH_EMS_PAGES        4
`define PERIPH_EMS_DISABLE_CODE 8'hFF
`define PERIPH_EMS_ENABLE_LIMIT 8'h80

// Frame selectors for address bits 19-16
`define PERIPH_FRAME_A          4'hA
`define PERIPH_FRAME_C          4'hC
`define PERIPH_FRAME_D          4'hD

// Reset values
`define PERIPH_EMS_PAGE_RESET   7'h00
`define PERIPH_KBD_RESET        8'h00

`endif

//--- verilog/periph_bus_pkg.sv
/*
 * Bus types shared by the peripheral glue:
 * CPU address, I/O port number, data byte and read-back source
 */

`default_nettype none

package periph_bus_pkg;

    // 20-bit CPU address
    typedef logic [19:0] addr_t;

    // Lower 16 bits of the address during I/O cycles
    typedef logic [15:0] io_port_t;

    typedef logic [7:0] data_t;

    // Winner of the read-back arbitration
    typedef enum logic [1:0] {
        RB_NONE = 2'd0,
        RB_EMS  = 2'd1,
        RB_KBD  = 2'd2
    } rb_source_e;

endpackage

`default_nettype wire

//--- verilog/ems_pkg.sv
/*
 * EMS mapper types: page number, register index,
 * frame choice and per-page block hit flags
 */

`default_nettype none

`include "periph_config.svh"

package ems_pkg;

    // Page number held in one page register
    typedef logic [6:0] ems_page_t;

    // Selects one of the page registers
    typedef logic [1:0] ems_index_t;

    // 0 = A0000h, 1 = C0000h, others = D0000h
    typedef logic [1:0] frame_sel_t;

    typedef logic [`PERIPH_EMS_PAGES-1:0] block_hits_t;

endpackage

`default_nettype wire

//--- verilog/io_cycle_if.sv
/*
 * One CPU bus cycle as seen by the peripherals:
 * address, write data and decoded cycle flags
 */

`default_nettype none

interface io_cycle_if;

    periph_bus_pkg::addr_t addr;
    periph_bus_pkg::data_t wdata;
    logic                  io_read;
    logic                  io_write;
    logic                  memory;

    modport source (output addr, output wdata, output io_read, output io_write, output memory);

    modport peer (input addr, input wdata, input io_read, input io_write, input memory);

endinterface

`default_nettype wire

//--- verilog/io_decoder.sv
/*
 * Fixed I/O window decoder for 000h-0FFh.
 * Produces the DMA and DMA page selects and the keyboard port select
 */

`default_nettype none

`include "periph_config.svh"

module io_decoder (
    io_cycle_if.peer    bus_i,
    output logic        dma_chip_select_n_o,
    output logic        dma_page_chip_select_n_o,
    output logic        kbd_select_o
);

    localparam periph_bus_pkg::io_port_t KBD_PORT = `PERIPH_KBD_PORT;

    logic                     iorq;
    logic [7:0]               chip_select_n;
    periph_bus_pkg::io_port_t port;

    assign iorq = bus_i.io_read | bus_i.io_write;
    assign port = bus_i.addr[15:0];

    // Eight 32-byte slots inside the low 256 ports
    always_comb begin
        chip_select_n = 8'hFF;
        if (~bus_i.addr[9] && ~bus_i.addr[8]) begin
            chip_select_n[bus_i.addr[7:5]] = 1'b0;
        end
    end

    // Slot 0 is the DMA controller, slot 4 the page registers
    assign dma_chip_select_n_o      = ~(iorq && ~chip_select_n[0]);
    assign dma_page_chip_select_n_o = ~(iorq && ~chip_select_n[4]);

    assign kbd_select_o = iorq && (port == KBD_PORT);

endmodule

`default_nettype wire

//--- verilog/ems_mapper.sv
/*
 * EMS page mapper: four page registers at 260h-263h,
 * registered write stage, frame block hits and register read-back
 */

`default_nettype none

`include "periph_config.svh"

module ems_mapper (
    input  logic                  clock,
    input  logic                  reset,
    io_cycle_if.peer              bus_i,
    input  logic                  ems_enabled_i,
    input  ems_pkg::frame_sel_t   ems_frame_i,
    output ems_pkg::block_hits_t  block_hit_o,
    output logic                  rd_req_o,
    output periph_bus_pkg::data_t rd_data_o
);

    localparam periph_bus_pkg::io_port_t EMS_BASE = `PERIPH_EMS_PORT_BASE;

    ems_pkg::ems_page_t          page_num [`PERIPH_EMS_PAGES];
    logic [`PERIPH_EMS_PAGES-1:0] page_enabled;

    periph_bus_pkg::io_port_t port;
    ems_pkg::ems_index_t      index;
    logic                     ems_select;
    logic                     write_accept;
    logic [3:0]               frame_base;

    logic                     wr_pending;
    ems_pkg::ems_index_t      wr_index;
    ems_pkg::ems_page_t       wr_page;
    logic                     wr_enable;

    assign port       = bus_i.addr[15:0];
    assign index      = bus_i.addr[1:0];
    assign ems_select = ems_enabled_i && (port[15:2] == EMS_BASE[15:2])
                        && (bus_i.io_read || bus_i.io_write);

    // Only FFh and values below 80h change a register
    assign write_accept = (bus_i.wdata == `PERIPH_EMS_DISABLE_CODE)
                          || (bus_i.wdata < `PERIPH_EMS_ENABLE_LIMIT);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_pending <= 1'b0;
        end else begin
            wr_pending <= ems_select && bus_i.io_write && write_accept;
        end
    end

    always_ff @(posedge clock) begin
        wr_index  <= index;
        wr_page   <= bus_i.wdata[6:0];
        wr_enable <= (bus_i.wdata != `PERIPH_EMS_DISABLE_CODE);
    end

    // Page update one edge after the write stage
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `PERIPH_EMS_PAGES; i++) begin
                page_num[i] <= `PERIPH_EMS_PAGE_RESET;
            end
            page_enabled <= '0;
        end else if (wr_pending) begin
            if (wr_enable) begin
                page_num[wr_index] <= wr_page;
            end
            page_enabled[wr_index] <= wr_enable;
        end
    end

    always_comb begin
        case (ems_frame_i)
            2'd0:    frame_base = `PERIPH_FRAME_A;
            2'd1:    frame_base = `PERIPH_FRAME_C;
            default: frame_base = `PERIPH_FRAME_D;
        endcase
    end

    // One 16 KB block per page inside the frame
    always_comb begin
        for (int i = 0; i < `PERIPH_EMS_PAGES; i++) begin
            block_hit_o[i] = bus_i.memory && page_enabled[i]
                             && (bus_i.addr[19:14] == {frame_base, ems_pkg::ems_index_t'(i)});
        end
    end

    assign rd_req_o  = ems_select && bus_i.io_read;
    assign rd_data_o = page_enabled[index] ? {1'b0, page_num[index]}
                                           : `PERIPH_EMS_DISABLE_CODE;

endmodule

`default_nettype wire

//--- verilog/keyboard_port.sv
/*
 * Keyboard data port at 60h: two-stage scancode pipeline
 * and two-cycle delay of the keyboard interrupt request
 */

`default_nettype none

`include "periph_config.svh"

module keyboard_port (
    input  logic                  clock,
    input  logic                  reset,
    io_cycle_if.peer              bus_i,
    input  logic                  kbd_select_i,
    input  periph_bus_pkg::data_t keycode_i,
    input  logic                  keyboard_irq_i,
    output logic                  keyboard_interrupt_o,
    output logic                  rd_req_o,
    output periph_bus_pkg::data_t rd_data_o
);

    periph_bus_pkg::data_t keycode_ff;
    periph_bus_pkg::data_t port_a;
    logic                  irq_ff;

    // Scancode into the port A byte
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            keycode_ff <= `PERIPH_KBD_RESET;
            port_a     <= `PERIPH_KBD_RESET;
        end else begin
            keycode_ff <= keycode_i;
            port_a     <= keycode_ff;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            irq_ff               <= 1'b0;
            keyboard_interrupt_o <= 1'b0;
        end else begin
            irq_ff               <= keyboard_irq_i;
            keyboard_interrupt_o <= irq_ff;
        end
    end

    assign rd_req_o  = kbd_select_i && bus_i.io_read;
    assign rd_data_o = port_a;

endmodule

`default_nettype wire

//--- verilog/readback_arbiter.sv
/*
 * Fixed-priority read-back arbiter, EMS before keyboard,
 * with a registered read-data byte and valid flag
 */

`default_nettype none

module readback_arbiter (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  ems_req_i,
    input  logic                  kbd_req_i,
    input  periph_bus_pkg::data_t ems_data_i,
    input  periph_bus_pkg::data_t kbd_data_i,
    output periph_bus_pkg::data_t data_o,
    output logic                  valid_o
);

    periph_bus_pkg::rb_source_e source;

    always_comb begin
        if (ems_req_i) begin
            source = periph_bus_pkg::RB_EMS;
        end else if (kbd_req_i) begin
            source = periph_bus_pkg::RB_KBD;
        end else begin
            source = periph_bus_pkg::RB_NONE;
        end
    end

    // Bus idles at zero with valid low
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_o  <= '0;
            valid_o <= 1'b0;
        end else begin
            case (source)
                periph_bus_pkg::RB_EMS: begin
                    data_o  <= ems_data_i;
                    valid_o <= 1'b1;
                end
                periph_bus_pkg::RB_KBD: begin
                    data_o  <= kbd_data_i;
                    valid_o <= 1'b1;
                end
                default: begin
                    data_o  <= '0;
                    valid_o <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/periph_top.sv
/*
 * Peripheral glue top level: bus cycle decode into the shared
 * interface, I/O decoder, EMS mapper, keyboard port and read-back arbiter
 */

`default_nettype none

module periph_top (
    input  logic                  clock,
    input  logic                  reset,
    input  periph_bus_pkg::addr_t address_i,
    input  periph_bus_pkg::data_t data_i,
    input  logic                  io_read_n_i,
    input  logic                  io_write_n_i,
    input  logic                  address_enable_n_i,
    input  logic                  ems_enabled_i,
    input  ems_pkg::frame_sel_t   ems_frame_i,
    input  periph_bus_pkg::data_t keycode_i,
    input  logic                  keyboard_irq_i,
    output periph_bus_pkg::data_t data_bus_out_o,
    output logic                  data_bus_out_from_chipset_o,
    output logic                  dma_chip_select_n_o,
    output logic                  dma_page_chip_select_n_o,
    output ems_pkg::block_hits_t  ems_block_hit_o,
    output logic                  keyboard_interrupt_o
);

    io_cycle_if bus ();

    logic                  kbd_select;
    logic                  ems_rd_req;
    logic                  kbd_rd_req;
    periph_bus_pkg::data_t ems_rd_data;
    periph_bus_pkg::data_t kbd_rd_data;

    assign bus.addr     = address_i;
    assign bus.wdata    = data_i;
    assign bus.io_read  = ~io_read_n_i && ~address_enable_n_i;
    assign bus.io_write = ~io_write_n_i && ~address_enable_n_i;
    assign bus.memory   = io_read_n_i && io_write_n_i;

    io_decoder u_io_decoder (
        .bus_i                    (bus.peer),
        .dma_chip_select_n_o      (dma_chip_select_n_o),
        .dma_page_chip_select_n_o (dma_page_chip_select_n_o),
        .kbd_select_o             (kbd_select)
    );

    ems_mapper u_ems_mapper (
        .clock         (clock),
        .reset         (reset),
        .bus_i         (bus.peer),
        .ems_enabled_i (ems_enabled_i),
        .ems_frame_i   (ems_frame_i),
        .block_hit_o   (ems_block_hit_o),
        .rd_req_o      (ems_rd_req),
        .rd_data_o     (ems_rd_data)
    );

    keyboard_port u_keyboard_port (
        .clock                (clock),
        .reset                (reset),
        .bus_i                (bus.peer),
        .kbd_select_i         (kbd_select),
        .keycode_i            (keycode_i),
        .keyboard_irq_i       (keyboard_irq_i),
        .keyboard_interrupt_o (keyboard_interrupt_o),
        .rd_req_o             (kbd_rd_req),
        .rd_data_o            (kbd_rd_data)
    );

    readback_arbiter u_readback_arbiter (
        .clock      (clock),
        .reset      (reset),
        .ems_req_i  (ems_rd_req),
        .kbd_req_i  (kbd_rd_req),
        .ems_data_i (ems_rd_data),
        .kbd_data_i (kbd_rd_data),
        .data_o     (data_bus_out_o),
        .valid_o    (data_bus_out_from_chipset_o)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
/*
 * Free-running testbench clock
 */

`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clock_o
);

    initial begin
        clock_o = 1'b0;
        forever #(PERIOD / 2) clock_o = ~clock_o;
    end

endmodule

`default_nettype wire

//--- tests/periph_properties.sv
/*
 * Concurrent checks on the peripheral top level: one-hot block hits,
 * idle read-back bus and the two-cycle keyboard interrupt delay
 */

`default_nettype none

module periph_properties (
    input logic                  clock,
    input logic                  reset,
    input logic                  kbd_irq_i,
    input logic                  kbd_int_i,
    input periph_bus_pkg::data_t rd_data_i,
    input logic                  rd_valid_i,
    input ems_pkg::block_hits_t  block_hit_i
);

    int unsigned hit_fails = 0;
    int unsigned idle_fails = 0;
    int unsigned irq_fails = 0;
    int unsigned fail_count;

    assign fail_count = hit_fails + idle_fails + irq_fails;

    // At most one 16 KB block of the frame matches
    hits_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(block_hit_i))
        else begin
            hit_fails++;
            $error("more than one EMS block hit: %b", block_hit_i);
        end

    bus_idle_zero: assert property (@(posedge clock) disable iff (reset)
        !rd_valid_i |-> rd_data_i == 8'h00)
        else begin
            idle_fails++;
            $error("read-back data %h while no chipset data", rd_data_i);
        end

    // Two flops between request and interrupt
    irq_delay: assert property (@(posedge clock) disable iff (reset)
        kbd_int_i == $past(kbd_irq_i, 2))
        else begin
            irq_fails++;
            $error("keyboard interrupt does not follow the request by two cycles");
        end

endmodule

bind periph_top periph_properties u_properties (
    .clock       (clock),
    .reset       (reset),
    .kbd_irq_i   (keyboard_irq_i),
    .kbd_int_i   (keyboard_interrupt_o),
    .rd_data_i   (data_bus_out_o),
    .rd_valid_i  (data_bus_out_from_chipset_o),
    .block_hit_i (ems_block_hit_o)
);

`default_nettype wire

//--- tests/periph_tb.sv
/*
 * Testbench for periph_top: EMS page registers and frame hits,
 * keyboard port pipeline and I/O select decoding
 */

`default_nettype none

`include "periph_config.svh"

module periph_tb;

    localparam int          IDLE_TIMEOUT = 16;
    localparam logic [15:0] EMS_BASE     = `PERIPH_EMS_PORT_BASE;

    logic                  clock;
    logic                  reset;
    periph_bus_pkg::addr_t address;
    periph_bus_pkg::data_t data;
    logic                  io_read_n;
    logic                  io_write_n;
    logic                  aen_n;
    logic                  ems_enabled;
    ems_pkg::frame_sel_t   ems_frame;
    periph_bus_pkg::data_t keycode;
    logic                  kbd_irq;
    periph_bus_pkg::data_t rd_data;
    logic                  rd_valid;
    logic                  dma_cs_n;
    logic                  dma_page_cs_n;
    ems_pkg::block_hits_t  block_hit;
    logic                  kbd_int;

    // Model of the page registers and the keyboard history
    logic [6:0]            model_page [4];
    logic [3:0]            model_en;
    periph_bus_pkg::data_t kc_hist [2];
    logic [1:0]            irq_hist;

    logic                  exp_read;
    periph_bus_pkg::data_t exp_data;
    logic                  chk_armed = 1'b0;
    logic                  chk_read = 1'b0;
    periph_bus_pkg::data_t chk_data = 8'h00;
    int unsigned           value_errors = 0;
    int unsigned           read_errors = 0;
    int unsigned           timeouts = 0;
    integer                seed;

    tb_clock_gen #(.PERIOD(8)) u_clock_gen (.clock_o(clock));

    periph_top i_dut (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_i                      (data),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .address_enable_n_i          (aen_n),
        .ems_enabled_i               (ems_enabled),
        .ems_frame_i                 (ems_frame),
        .keycode_i                   (keycode),
        .keyboard_irq_i              (kbd_irq),
        .data_bus_out_o              (rd_data),
        .data_bus_out_from_chipset_o (rd_valid),
        .dma_chip_select_n_o         (dma_cs_n),
        .dma_page_chip_select_n_o    (dma_page_cs_n),
        .ems_block_hit_o             (block_hit),
        .keyboard_interrupt_o        (kbd_int)
    );

    // Expected EMS read byte, plus the expected block hits of the cycle
    function automatic periph_bus_pkg::data_t ems_expect(input periph_bus_pkg::addr_t addr,
                                                         input logic mem_cycle,
                                                         output ems_pkg::block_hits_t hits);
        logic [3:0] base;
        base = (ems_frame == 2'd0) ? 4'hA : ((ems_frame == 2'd1) ? 4'hC : 4'hD);
        for (int n = 0; n < 4; n++) begin
            hits[n] = mem_cycle && model_en[n] && (addr[19:14] == {base, 2'(n)});
        end
        return model_en[addr[1:0]] ? {1'b0, model_page[addr[1:0]]} : 8'hFF;
    endfunction

    // FFh disables, below 80h enables, anything else is ignored
    function automatic void model_write(input logic [1:0] idx, input periph_bus_pkg::data_t value);
        if (value == 8'hFF) begin
            model_en[idx] = 1'b0;
        end else if (value < 8'h80) begin
            model_en[idx]   = 1'b1;
            model_page[idx] = value[6:0];
        end
    endfunction

    // One cycle from falling edge to falling edge with a new keycode and IRQ
    task automatic bus_cycle(input periph_bus_pkg::addr_t addr, input periph_bus_pkg::data_t wdata,
                             input logic rd, input logic wr);
        ems_pkg::block_hits_t  want_hits;
        periph_bus_pkg::data_t ems_byte;
        logic                  iorq;
        address    = addr;
        data       = wdata;
        io_read_n  = ~rd;
        io_write_n = ~wr;
        kc_hist[1] = kc_hist[0];
        kc_hist[0] = keycode;
        irq_hist   = {irq_hist[0], kbd_irq};
        keycode    = 8'($random(seed));
        kbd_irq    = 1'($random(seed));
        iorq       = (rd || wr) && !aen_n;
        ems_byte   = ems_expect(addr, !rd && !wr, want_hits);
        exp_read   = 1'b0;
        exp_data   = 8'h00;
        if (rd && !aen_n && addr[15:0] == `PERIPH_KBD_PORT) begin
            exp_read = 1'b1;
            exp_data = kc_hist[1];
        end else if (rd && !aen_n && ems_enabled && addr[15:2] == EMS_BASE[15:2]) begin
            exp_read = 1'b1;
            exp_data = ems_byte;
        end
        #2;
        if (block_hit !== want_hits) begin
            value_errors++;
            $display("ERR %0t: block hits %b, expected %b at %h", $time, block_hit, want_hits, addr);
        end
        if (dma_cs_n !== !(iorq && addr[9:5] == 5'd0)
                || dma_page_cs_n !== !(iorq && addr[9:5] == 5'd4)) begin
            value_errors++;
            $display("ERR %0t: DMA selects %b %b wrong at %h", $time, dma_cs_n, dma_page_cs_n, addr);
        end
        if (kbd_int !== irq_hist[1]) begin
            value_errors++;
            $display("ERR %0t: keyboard interrupt %b, expected %b", $time, kbd_int, irq_hist[1]);
        end
        @(negedge clock);
    endtask

    task automatic ems_write(input logic [1:0] idx, input periph_bus_pkg::data_t value);
        bus_cycle({4'h0, EMS_BASE[15:2], idx}, value, 1'b0, 1'b1);
        bus_cycle('0, 8'h00, 1'b0, 1'b0);
        model_write(idx, value);
    endtask

    // Memory and I/O cycles over each block of high nibbles 9h to Eh
    task automatic sweep_frames();
        periph_bus_pkg::addr_t addr;
        for (int f = 0; f < 4; f++) begin
            ems_frame = 2'(f);
            for (int b = 9; b < 15; b++) begin
                for (int n = 0; n < 4; n++) begin
                    addr = {4'(b), 2'(n), 14'($random(seed))};
                    bus_cycle(addr, 8'h00, 1'b0, 1'b0);
                    bus_cycle(addr, 8'h00, 1'b1, 1'b0);
                end
            end
        end
    endtask

    task automatic wait_readback_idle(input string what);
        int cycles;
        cycles = 0;
        while (rd_valid !== 1'b0 && cycles < IDLE_TIMEOUT) begin
            bus_cycle('0, 8'h00, 1'b0, 1'b0);
            cycles++;
        end
        if (rd_valid !== 1'b0) begin
            timeouts++;
            $display("Timeout: read-back bus did not go idle %s", what);
        end
    endtask

    // Registered read-back checked on the falling edge after the sampling edge
    always @(posedge clock) begin
        chk_armed <= !reset;
        chk_read  <= exp_read;
        chk_data  <= exp_data;
    end

    always @(negedge clock) begin
        if (chk_armed && (rd_valid !== chk_read || rd_data !== (chk_read ? chk_data : 8'h00))) begin
            read_errors++;
            $display("ERR %0t: read-back %h valid %b, expected %h valid %b",
                     $time, rd_data, rd_valid, chk_data, chk_read);
        end
    end

    initial begin
        logic [1:0]            idx;
        periph_bus_pkg::data_t value;
        seed        = 32'ha9d6;
        reset       = 1'b1;
        address     = '0;
        data        = '0;
        io_read_n   = 1'b1;
        io_write_n  = 1'b1;
        aen_n       = 1'b0;
        ems_enabled = 1'b1;
        ems_frame   = 2'd0;
        keycode     = '0;
        kbd_irq     = 1'b0;
        kc_hist     = '{default: '0};
        irq_hist    = '0;
        exp_read    = 1'b0;
        exp_data    = '0;
        model_en    = '0;
        model_page  = '{default: '0};
        repeat (10) @(negedge clock);
        reset = 1'b0;
        wait_readback_idle("after reset");

        // Reset state of the pages and frames
        for (int i = 0; i < 4; i++) begin
            bus_cycle({4'h0, EMS_BASE[15:2], 2'(i)}, 8'h00, 1'b1, 1'b0);
        end
        sweep_frames();

        for (int i = 0; i < 40; i++) begin
            idx   = 2'($random(seed));
            value = (i % 6 == 5) ? 8'hFF : 8'($random(seed));
            ems_write(idx, value);
            bus_cycle({4'h0, EMS_BASE[15:2], idx}, 8'h00, 1'b1, 1'b0);
        end

        // Pages 0 to 2 mapped and page 3 off
        ems_write(2'd0, 8'h11);
        ems_write(2'd1, 8'h7F);
        ems_write(2'd2, 8'h00);
        ems_write(2'd3, 8'hFF);
        sweep_frames();

        for (int i = 0; i < 24; i++) begin
            bus_cycle(20'h00060, 8'h00, 1'b1, 1'b0);
            if (i % 3 == 2) begin
                bus_cycle('0, 8'h00, 1'b0, 1'b0);
            end
        end

        for (int p = 0; p < 256; p += 7) begin
            bus_cycle(20'(p), 8'($random(seed)), 1'b0, 1'b1);
            bus_cycle(20'(p), 8'h00, 1'b1, 1'b0);
            bus_cycle(20'(p), 8'h00, 1'b0, 1'b0);
        end

        // DMA cycles with AEN high select nothing
        aen_n = 1'b1;
        bus_cycle(20'h00003, 8'h00, 1'b1, 1'b0);
        bus_cycle(20'h00083, 8'h00, 1'b0, 1'b1);
        bus_cycle({4'h0, EMS_BASE}, 8'h00, 1'b1, 1'b0);
        aen_n = 1'b0;

        ems_enabled = 1'b0;
        for (int i = 0; i < 4; i++) begin
            bus_cycle({4'h0, EMS_BASE[15:2], 2'(i)}, 8'h00, 1'b1, 1'b0);
        end
        ems_enabled = 1'b1;
        wait_readback_idle("at the end of the run");

        // Let the last falling-edge compare finish first
        @(posedge clock);

        $display("Done: %0d value errors, %0d read-back errors, %0d timeouts, %0d %s",
                 value_errors, read_errors, timeouts, i_dut.u_properties.fail_count,
                 "assertion failures");
        if (value_errors == 0 && read_errors == 0 && timeouts == 0
                && i_dut.u_properties.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- periph.f
+incdir+include
verilog/periph_bus_pkg.sv
verilog/ems_pkg.sv
verilog/io_cycle_if.sv
verilog/io_decoder.sv
verilog/ems_mapper.sv
verilog/keyboard_port.sv
verilog/readback_arbiter.sv
verilog/periph_top.sv
tests/tb_clock_gen.sv
tests/periph_properties.sv
tests/periph_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -j 0 --top-module periph_tb -f periph.f -o periph_sim \
    && ./obj_dir/periph_sim +verilator+error+limit+1000 2>&1 | tee /dev/stderr | grep -qx "TB PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
